/* vlog.f */
common/cpu_pkg.sv
common/decode_if.sv
source/cpu_decoder.sv
source/cpu_reg_file.sv
source/cpu_alu.sv
source/cpu_pc_unit.sv
source/cpu_core.sv
testbench/tb_cpu_core.sv

/* Makefile */
# Verilator build and run for the rv32i subset core testbench

TOP   = tb_cpu_core
BUILD = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f vlog.f \
		--top-module $(TOP) -Mdir $(BUILD) -o sim_$(TOP)

run: compile
	./$(BUILD)/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf $(BUILD) sim.log

/* testbench/tb_cpu_core.sv */
// testbench for the rv32i subset core running a short program with random stalls
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_core;

    import cpu_pkg::*;

    localparam int    HALF_PERIOD = 50;             // 100 ns clock
    localparam int    SAMPLE_DLY  = 25;             // mid low phase
    localparam int    MAX_CYCLES  = 200;            // run timeout
    localparam int    NUM_INSTR   = 26;
    localparam word_t LOOP_ADDR   = 32'd100;        // beq x0,x0,0 lives here
    localparam int    OPC_IMM     = 'h13;
    localparam int    OPC_LOAD    = 'h03;
    localparam int    OPC_STORE   = 'h23;

    // register contents expected after the run
    localparam int    NUM_EXP = 17;
    localparam int    EXP_REG [NUM_EXP] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 15, 16};
    localparam word_t EXP_VAL [NUM_EXP] = '{
        32'h0000_0000, 32'h1234_5000, 32'h0000_00F0, 32'hFFFF_FFFF, 32'h0000_00FF,
        32'h0000_00FF, 32'h0000_0F00, 32'h0000_000F, 32'h1234_50F0, 32'h0000_00E1,
        32'h1234_5000, 32'h0000_00FF, 32'h0000_0020, 32'h1234_50F0, 32'h0000_00E1,
        32'h0000_0015, 32'h0000_0025
    };

    // stores in program order
    localparam int    NUM_STORES = 2;
    localparam word_t STORE_ADDR [NUM_STORES] = '{32'd36, 32'd24};
    localparam word_t STORE_DATA [NUM_STORES] = '{32'h1234_50F0, 32'h0000_00E1};

    logic      clk = 1'b0;
    logic      arst_n;
    logic      cpu_en;
    word_t     instr_addr;
    word_t     instr;
    word_t     addr_dm;
    logic      we_dm;
    word_t     wd_dm;
    word_t     rd_dm;
    reg_addr_t reg_addr;
    word_t     reg_data;

    word_t     prog [NUM_INSTR];                    // program table
    word_t     imem [0:63];
    word_t     dmem [0:63];
    int        store_idx;                           // next expected store
    int        cycle;
    logic      was_stall;
    word_t     held_pc;                             // fetch address seen in a stall

    always #HALF_PERIOD clk = ~clk;

    cpu_core cpu_core_inst (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .cpu_en     ( cpu_en     ),
        .instr_addr ( instr_addr ),
        .instr      ( instr      ),
        .addr_dm    ( addr_dm    ),
        .we_dm      ( we_dm      ),
        .wd_dm      ( wd_dm      ),
        .rd_dm      ( rd_dm      ),
        .reg_addr   ( reg_addr   ),
        .reg_data   ( reg_data   )
    );

    // memory models with combinational reads
    assign instr = imem[instr_addr[7:2]];
    assign rd_dm = dmem[addr_dm[7:2]];

    always @(posedge clk) begin
        if (we_dm) begin
            dmem[addr_dm[7:2]] <= wd_dm;            // word write
        end
    end

    // instruction encoders
    function automatic word_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
        enc_r = {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
    endfunction

    function automatic word_t enc_i(int imm, int rs1, int f3, int rd, int op);
        enc_i = {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'(op)};
    endfunction

    function automatic word_t enc_s(int imm, int rs2, int rs1);
        logic [11:0] i;
        i = 12'(imm);
        enc_s = {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_b(int off, int rs2, int rs1, int f3);
        logic [12:0] o;
        o = 13'(off);                               // byte offset with bit 0 dropped
        enc_b = {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic word_t enc_u(int upper, int rd);
        enc_u = {20'(upper), 5'(rd), 7'b0110111};
    endfunction

    task automatic load_program();
        prog[0]  = enc_u('h12345, 1);                  // lui x1
        prog[1]  = enc_i('h0F0, 0, 0, 2, OPC_IMM);     // addi x2, x0, 0xf0
        prog[2]  = enc_i(-1, 0, 0, 3, OPC_IMM);        // addi x3, x0, -1
        prog[3]  = enc_i('h0FF, 3, 7, 4, OPC_IMM);     // andi x4, x3, 0xff
        prog[4]  = enc_i('h00F, 2, 6, 5, OPC_IMM);     // ori x5, x2, 0xf
        prog[5]  = enc_i(4, 2, 1, 6, OPC_IMM);         // slli x6, x2, 4
        prog[6]  = enc_i(28, 3, 5, 7, OPC_IMM);        // srli x7, x3, 28
        prog[7]  = enc_r(0, 2, 1, 0, 8);               // add x8, x1, x2
        prog[8]  = enc_r('h20, 7, 2, 0, 9);            // sub x9, x2, x7
        prog[9]  = enc_r(0, 1, 3, 7, 10);              // and x10, x3, x1
        prog[10] = enc_r(0, 7, 2, 6, 11);              // or x11, x2, x7
        prog[11] = enc_i(5, 0, 0, 0, OPC_IMM);         // addi x0, x0, 5
        prog[12] = enc_i(32, 0, 0, 12, OPC_IMM);       // addi x12, x0, 32
        prog[13] = enc_s(4, 8, 12);                    // sw x8, 4(x12)
        prog[14] = enc_s(-8, 9, 12);                   // sw x9, -8(x12)
        prog[15] = enc_i(4, 12, 2, 13, OPC_LOAD);      // lw x13, 4(x12)
        prog[16] = enc_i(24, 0, 2, 14, OPC_LOAD);      // lw x14, 24(x0)
        prog[17] = enc_b(8, 11, 5, 0);                 // beq x5, x11 taken
        prog[18] = enc_i('h55, 0, 0, 5, OPC_IMM);      // skipped
        prog[19] = enc_b(8, 7, 2, 1);                  // bne x2, x7 taken
        prog[20] = enc_i('h66, 0, 0, 6, OPC_IMM);      // skipped
        prog[21] = enc_b(8, 7, 2, 0);                  // beq x2, x7 falls through
        prog[22] = enc_i('h15, 0, 0, 15, OPC_IMM);     // addi x15, x0, 0x15
        prog[23] = enc_b(8, 5, 4, 1);                  // bne x4, x5 falls through
        prog[24] = enc_i('h10, 15, 0, 16, OPC_IMM);    // addi x16, x15, 0x10
        prog[25] = enc_b(0, 0, 0, 0);                  // self loop
    endtask

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // compares one enabled store with the next table row
    task automatic check_store();
        if (store_idx >= NUM_STORES) begin
            $display("unexpected store to address %h at cycle %0d", addr_dm, cycle);
            abort_run();
        end
        check_word("addr_dm", addr_dm, STORE_ADDR[store_idx]);
        check_word("wd_dm", wd_dm, STORE_DATA[store_idx]);
        store_idx++;
    endtask

    initial begin
        arst_n    = 1'b0;
        cpu_en    = 1'b0;
        reg_addr  = '0;
        store_idx = 0;
        was_stall = 1'b0;
        held_pc   = '0;
        void'($urandom(64));
        load_program();
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < NUM_INSTR) ? prog[i] : enc_i(i, 0, 0, 0, OPC_IMM);  // nop fill
            dmem[i] = {16'hDA7A, 16'(i)};
        end

        repeat (8) @(negedge clk);
        check_word("instr_addr", instr_addr, 32'h0000_0000);
        check_bit("we_dm", we_dm, 1'b0);
        arst_n = 1'b1;
        #(SAMPLE_DLY);
        check_word("instr_addr", instr_addr, 32'h0000_0000);

        cycle = 0;
        while (instr_addr !== LOOP_ADDR) begin
            if (cycle >= MAX_CYCLES) begin
                $display("timeout: self-loop at %h not reached in %0d cycles", LOOP_ADDR, cycle);
                abort_run();
            end
            @(negedge clk);
            if (was_stall) begin
                check_word("instr_addr", instr_addr, held_pc);     // must hold over a stall
            end
            // each store is held back once before it may retire
            cpu_en = !(($urandom_range(3, 0) == 0) || (cycle % 7 == 3)
                       || ((instr[6:0] == 7'(OPC_STORE)) && !was_stall));
            #(SAMPLE_DLY);
            held_pc   = instr_addr;
            was_stall = !cpu_en;
            if (!cpu_en) begin
                check_bit("we_dm", we_dm, 1'b0);
            end else if (we_dm) begin
                check_store();
            end
            cycle++;
        end

        @(negedge clk);
        if (was_stall) begin
            check_word("instr_addr", instr_addr, held_pc);
        end
        cpu_en = 1'b0;                              // freeze before the scan
        check_word("store count", 32'(store_idx), 32'(NUM_STORES));

        for (int k = 0; k < NUM_EXP; k++) begin
            @(negedge clk);
            reg_addr = 5'(EXP_REG[k]);
            #(SAMPLE_DLY);
            check_word($sformatf("reg_data x%0d", EXP_REG[k]), reg_data, EXP_VAL[k]);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule : tb_cpu_core

`default_nettype wire

/* source/cpu_core.sv */
// cpu core executing an rv32i subset at one instruction per enabled clock
`timescale 1ns/10ps
`default_nettype none

module cpu_core (
    input  logic                clk,        // clock
    input  logic                arst_n,     // async reset, active low
    input  logic                cpu_en,     // run enable, stalls when low
    output cpu_pkg::word_t      instr_addr, // instruction fetch address
    input  cpu_pkg::word_t      instr,      // instruction, same cycle
    output cpu_pkg::word_t      addr_dm,    // data memory address
    output logic                we_dm,      // data memory write enable
    output cpu_pkg::word_t      wd_dm,      // data memory write data
    input  cpu_pkg::word_t      rd_dm,      // data memory read data
    input  cpu_pkg::reg_addr_t  reg_addr,   // debug scan index
    output cpu_pkg::word_t      reg_data    // debug scan value
);

    import cpu_pkg::*;

    reg_addr_t  ra1;                        // rs1 field
    reg_addr_t  ra2;                        // rs2 field
    reg_addr_t  wa;                         // rd field
    word_t      rd1;
    word_t      rd2;
    word_t      src_b;                      // alu operand b
    word_t      alu_result;
    word_t      wd_rf;                      // writeback data
    logic       we_rf_gated;                // rf write with stalls masked

    decode_if ctrl_if ();                   // decoder -> datapath

    // register fields
    assign ra1 = instr[19:15];
    assign ra2 = instr[24:20];
    assign wa  = instr[11:7];

    // datapath muxes
    assign src_b = ctrl_if.src_b_reg   ? rd2   : ctrl_if.imm;
    assign wd_rf = ctrl_if.rf_from_mem ? rd_dm : alu_result;   // lw vs alu

    // no side effects while stalled
    assign we_rf_gated = ctrl_if.we_rf && cpu_en;
    assign we_dm       = ctrl_if.we_dm && cpu_en;

    // data memory port
    assign addr_dm = alu_result;            // rs1 + imm for lw/sw
    assign wd_dm   = rd2;

    cpu_decoder cpu_decoder_inst (
        .instr      ( instr             ),
        .ctrl       ( ctrl_if.decoder   )
    );

    cpu_reg_file cpu_reg_file_inst (
        .clk        ( clk               ),
        .ra1        ( ra1               ),
        .ra2        ( ra2               ),
        .wa         ( wa                ),
        .ra_scan    ( reg_addr          ),  // debug scan
        .wd         ( wd_rf             ),
        .we         ( we_rf_gated       ),
        .rd1        ( rd1               ),
        .rd2        ( rd2               ),
        .rd_scan    ( reg_data          )
    );

    cpu_alu cpu_alu_inst (
        .src_a      ( rd1               ),
        .src_b      ( src_b             ),
        .alu_op     ( ctrl_if.alu_op    ),
        .result     ( alu_result        )
    );

    cpu_pc_unit cpu_pc_unit_inst (
        .clk        ( clk               ),
        .arst_n     ( arst_n            ),
        .cpu_en     ( cpu_en            ),
        .ctrl       ( ctrl_if.datapath  ),
        .rd1        ( rd1               ),
        .rd2        ( rd2               ),
        .pc         ( instr_addr        )
    );

    // stores are word sized and must be word aligned
    a_store_aligned : assert property (
        @(posedge clk) disable iff (!arst_n) we_dm |-> addr_dm[1:0] == 2'b00
    ) else $error("core: misaligned store address %h", addr_dm);

endmodule : cpu_core

`default_nettype wire

/* source/cpu_pc_unit.sv */
// cpu pc unit holding the program counter and resolving beq/bne targets
`timescale 1ns/10ps
`default_nettype none

module cpu_pc_unit (
    input  logic            clk,        // clock
    input  logic            arst_n,     // async reset, active low
    input  logic            cpu_en,     // advance enable
    decode_if.datapath      ctrl,       // branch control and b immediate
    input  cpu_pkg::word_t  rd1,        // rs1 value
    input  cpu_pkg::word_t  rd2,        // rs2 value
    output cpu_pkg::word_t  pc          // current fetch address
);

    import cpu_pkg::*;

    logic   regs_equal;                 // rs1 == rs2
    logic   branch_taken;
    word_t  pc_seq;                     // pc + 4
    word_t  pc_branch;                  // pc + offset
    word_t  pc_next;

    // branch comparison
    assign regs_equal   = (rd1 == rd2);
    assign branch_taken = ctrl.is_branch && (ctrl.branch_ne ? !regs_equal : regs_equal);

    // next address select
    assign pc_seq    = pc + PC_STEP;
    assign pc_branch = pc + (ctrl.imm << 1);    // restore implied bit 0
    assign pc_next   = branch_taken ? pc_branch : pc_seq;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (cpu_en) begin
            pc <= pc_next;                      // holds while stalled
        end
    end

    // only word-aligned fetches are legal
    a_pc_aligned : assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
        else $error("pc_unit: misaligned pc %h", pc);

endmodule : cpu_pc_unit

`default_nettype wire

/* source/cpu_alu.sv */
// cpu alu computing add, sub, and, or, logical shifts and the lui pass-through
`timescale 1ns/10ps
`default_nettype none

module cpu_alu (
    input  cpu_pkg::word_t      src_a,      // rs1 value
    input  cpu_pkg::word_t      src_b,      // rs2 value or immediate
    input  cpu_pkg::alu_op_t    alu_op,     // operation select
    output cpu_pkg::word_t      result      // also the data memory address
);

    import cpu_pkg::*;

    logic [SHAMT_W-1:0] shamt;              // shift amount

    assign shamt = src_b[SHAMT_W-1:0];      // imm shamt or rs2[4:0]

    always_comb begin
        case (alu_op)
            ALU_ADD: result = src_a + src_b;
            ALU_SUB: result = src_a - src_b;
            ALU_AND: result = src_a & src_b;
            ALU_OR:  result = src_a | src_b;
            ALU_SLL: result = src_a << shamt;
            ALU_SRL: result = src_a >> shamt;   // zero fill
            ALU_LUI: result = src_b;            // u-imm already in place
            default: result = '0;
        endcase
    end

endmodule : cpu_alu

`default_nettype wire

/* source/cpu_reg_file.sv */
// cpu register file with two read ports, one write port and a debug scan read port
`timescale 1ns/10ps
`default_nettype none

module cpu_reg_file (
    input  logic                clk,        // clock
    input  cpu_pkg::reg_addr_t  ra1,        // rs1 index
    input  cpu_pkg::reg_addr_t  ra2,        // rs2 index
    input  cpu_pkg::reg_addr_t  wa,         // rd index
    input  cpu_pkg::reg_addr_t  ra_scan,    // debug index
    input  cpu_pkg::word_t      wd,         // write data
    input  logic                we,         // write enable, already gated
    output cpu_pkg::word_t      rd1,        // rs1 value
    output cpu_pkg::word_t      rd2,        // rs2 value
    output cpu_pkg::word_t      rd_scan     // debug value
);

    import cpu_pkg::*;

    word_t regs [0:NUM_REGS-1];             // entry 0 never written

    // write port, x0 is hardwired
    always_ff @(posedge clk) begin
        if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // combinational reads, x0 forced to zero
    assign rd1     = (ra1 == '0)     ? '0 : regs[ra1];
    assign rd2     = (ra2 == '0)     ? '0 : regs[ra2];
    assign rd_scan = (ra_scan == '0) ? '0 : regs[ra_scan];   // no effect on execution

    // write address must be resolved whenever a write is requested
    a_wa_known : assert property (@(posedge clk) we |-> !$isunknown(wa))
        else $error("reg_file: unknown write address with we high");

endmodule : cpu_reg_file

`default_nettype wire

/* source/cpu_decoder.sv */
// cpu decoder turning the instruction word into control levels and a sign extended immediate
`timescale 1ns/10ps
`default_nettype none

module cpu_decoder (
    input  cpu_pkg::word_t  instr,      // fetched instruction
    decode_if.decoder       ctrl        // decoded control out
);

    import cpu_pkg::*;

    logic [6:0] opcode;                 // instr[6:0]
    logic [2:0] funct3;                 // instr[14:12]
    logic [6:0] funct7;                 // instr[31:25]
    imm_sel_t   imm_sel;                // immediate layout
    alu_op_t    alu_op;
    logic       src_b_reg;
    logic       we_rf;
    logic       we_dm;
    logic       rf_from_mem;
    logic       is_branch;
    logic       branch_ne;
    word_t      imm;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // control unit
    always_comb begin
        alu_op      = ALU_ADD;          // defaults have no side effects
        imm_sel     = IMM_I;
        src_b_reg   = 1'b0;
        we_rf       = 1'b0;
        we_dm       = 1'b0;
        rf_from_mem = 1'b0;
        is_branch   = 1'b0;
        branch_ne   = 1'b0;
        case (opcode)
            OP_LUI: begin
                alu_op  = ALU_LUI;      // upper imm straight through
                imm_sel = IMM_U;
                we_rf   = 1'b1;
            end
            OP_IMM: begin
                we_rf = 1'b1;
                case (funct3)
                    F3_ADD:  alu_op = ALU_ADD;
                    F3_SLL:  alu_op = ALU_SLL;  // shamt in imm[4:0]
                    F3_SRL:  alu_op = ALU_SRL;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: we_rf  = 1'b0;     // unsupported funct3
                endcase
            end
            OP_REG: begin
                src_b_reg = 1'b1;
                we_rf     = 1'b1;
                case (funct3)
                    F3_ADD:  alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLL:  alu_op = ALU_SLL;  // shamt from rs2[4:0]
                    F3_SRL:  alu_op = ALU_SRL;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: we_rf  = 1'b0;
                endcase
            end
            OP_LOAD: begin
                we_rf       = 1'b1;     // address = rs1 + imm_i
                rf_from_mem = 1'b1;
            end
            OP_STORE: begin
                imm_sel = IMM_S;
                we_dm   = 1'b1;
            end
            OP_BRANCH: begin
                imm_sel   = IMM_B;
                src_b_reg = 1'b1;       // alu result unused here
                case (funct3)
                    F3_BEQ:  is_branch = 1'b1;
                    F3_BNE: begin
                        is_branch = 1'b1;
                        branch_ne = 1'b1;
                    end
                    default: is_branch = 1'b0;
                endcase
            end
            default: alu_op = ALU_ADD;  // unknown opcode acts as a nop
        endcase
    end

    // immediate generator with bit 0 of the b offset implied
    always_comb begin
        case (imm_sel)
            IMM_U:   imm = {instr[31:12], 12'b0};
            IMM_B:   imm = {{20{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8]};
            IMM_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    assign ctrl.alu_op      = alu_op;
    assign ctrl.src_b_reg   = src_b_reg;
    assign ctrl.we_rf       = we_rf;
    assign ctrl.we_dm       = we_dm;
    assign ctrl.rf_from_mem = rf_from_mem;
    assign ctrl.is_branch   = is_branch;
    assign ctrl.branch_ne   = branch_ne;
    assign ctrl.imm         = imm;

endmodule : cpu_decoder

`default_nettype wire

/* common/decode_if.sv */
// decode interface carrying control levels and the extended immediate to the datapath
`timescale 1ns/10ps
`default_nettype none

interface decode_if ();

    import cpu_pkg::*;

    alu_op_t    alu_op;         // alu operation
    logic       src_b_reg;      // src b from rs2, else immediate
    logic       we_rf;          // register file write
    logic       we_dm;          // data memory write
    logic       rf_from_mem;    // writeback from rd_dm
    logic       is_branch;      // conditional branch
    logic       branch_ne;      // bne when set, beq otherwise
    word_t      imm;            // sign extended immediate

    // control unit side
    modport decoder (
        output alu_op, src_b_reg, we_rf, we_dm,
        output rf_from_mem, is_branch, branch_ne, imm
    );

    // consumers in the core
    modport datapath (
        input  alu_op, src_b_reg, we_rf, we_dm,
        input  rf_from_mem, is_branch, branch_ne, imm
    );

endinterface : decode_if

`default_nettype wire

/* common/cpu_pkg.sv */
// cpu package with shared word types, rv32i opcode fields and alu/immediate encodings
`default_nettype none

package cpu_pkg;

    localparam int XLEN     = 32;                   // datapath width
    localparam int REG_AW   = 5;                    // register index width
    localparam int NUM_REGS = 32;                   // architectural regs incl x0
    localparam int SHAMT_W  = 5;                    // shift amount bits

    typedef logic [XLEN-1:0]   word_t;              // data or address word
    typedef logic [REG_AW-1:0] reg_addr_t;          // register index

    // alu operation select
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,                             // a + b
        ALU_SUB = 3'd1,                             // a - b
        ALU_AND = 3'd2,                             // bitwise and
        ALU_OR  = 3'd3,                             // bitwise or
        ALU_SLL = 3'd4,                             // shift left logical
        ALU_SRL = 3'd5,                             // shift right logical
        ALU_LUI = 3'd6                              // pass src b
    } alu_op_t;

    // immediate field layout
    typedef enum logic [1:0] {
        IMM_I = 2'd0,                               // addi, lw
        IMM_U = 2'd1,                               // lui
        IMM_B = 2'd2,                               // beq, bne
        IMM_S = 2'd3                                // sw
    } imm_sel_t;

    // major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;  // u-type
    localparam logic [6:0] OP_IMM    = 7'b0010011;  // reg-imm alu
    localparam logic [6:0] OP_REG    = 7'b0110011;  // reg-reg alu
    localparam logic [6:0] OP_LOAD   = 7'b0000011;  // lw
    localparam logic [6:0] OP_STORE  = 7'b0100011;  // sw
    localparam logic [6:0] OP_BRANCH = 7'b1100011;  // beq, bne

    // funct3 values
    localparam logic [2:0] F3_ADD = 3'b000;         // add, addi, sub
    localparam logic [2:0] F3_SLL = 3'b001;         // slli
    localparam logic [2:0] F3_SRL = 3'b101;         // srli
    localparam logic [2:0] F3_OR  = 3'b110;         // or, ori
    localparam logic [2:0] F3_AND = 3'b111;         // and, andi
    localparam logic [2:0] F3_BEQ = 3'b000;         // branch if equal
    localparam logic [2:0] F3_BNE = 3'b001;         // branch if not equal

    // funct7 marks sub vs add
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // program counter constants
    localparam word_t PC_STEP  = 32'd4;             // sequential increment
    localparam word_t RESET_PC = 32'h0000_0000;     // first fetch address

endpackage : cpu_pkg

`default_nettype wire
